// ==== hdl/dispatch_cfg_pkg.sv ====
package dispatch_cfg_pkg;

    // instructions entering from rename per cycle
    localparam int RENAME_WIDTH     = 2;

    // integer dispatch queue
    localparam int INTDQ_DEPTH      = 8;
    localparam int INTDQ_DISP_WID   = 2;
    localparam int INTDQ_PTR_W      = $clog2(INTDQ_DEPTH);
    localparam int INTDQ_CNT_W      = $clog2(INTDQ_DEPTH + 1);

    // immediate buffer
    localparam int IMMBUF_SIZE      = 8;
    localparam int IMMBUF_READ_NUM  = 2;
    localparam int IMMBUF_CLEAR_NUM = 2;
    localparam int IMMBUF_CNT_W     = $clog2(IMMBUF_SIZE + 1);

    // field widths
    localparam int ROB_IDX_W        = 5;
    localparam int PREG_IDX_W       = 6;
    localparam int LREG_IDX_W       = 5;
    localparam int FTQ_IDX_W        = 4;
    localparam int FTQ_OFFSET_W     = 3;
    localparam int IMM_W            = 20;
    localparam int IRB_IDX_W        = 3;

endpackage

// ==== hdl/dispatch_types_pkg.sv ====
package dispatch_types_pkg;
    import dispatch_cfg_pkg::*;

    typedef logic [ROB_IDX_W-1:0]    rob_idx_t;
    typedef logic [PREG_IDX_W-1:0]   preg_idx_t;
    typedef logic [LREG_IDX_W-1:0]   lreg_idx_t;
    typedef logic [FTQ_IDX_W-1:0]    ftq_idx_t;
    typedef logic [FTQ_OFFSET_W-1:0] ftq_offset_t;
    typedef logic [IMM_W-1:0]        imm_t;
    typedef logic [IRB_IDX_W-1:0]    irb_idx_t;

    // which dispatch queue an instruction belongs to
    typedef enum logic [0:0] {
        BLK_INT = 1'b0,
        BLK_MEM = 1'b1
    } disp_block_e;

    typedef enum logic [2:0] {
        UOP_ALU    = 3'd0,
        UOP_BRANCH = 3'd1,
        UOP_LOAD   = 3'd2,
        UOP_STORE  = 3'd3,
        UOP_MV     = 3'd4
    } micro_op_e;

    // front-end and decode exceptions only
    typedef enum logic [1:0] {
        EXC_NONE          = 2'd0,
        EXC_ILLEGAL_INST  = 2'd1,
        EXC_MISALIGNED_PC = 2'd2
    } except_e;

    typedef struct packed {
        ftq_idx_t    ftq_idx;
        ftq_offset_t ftq_offset;
        logic        is_rvc;
        logic        is_mv;
        logic        rd_wen;
        lreg_idx_t   lrd_idx;
        preg_idx_t   prd_idx;
        preg_idx_t   prev_prd_idx;
        preg_idx_t   prs1_idx;
        preg_idx_t   prs2_idx;
        logic        use_imm;
        imm_t        imm20;
        disp_block_e block_id;
        micro_op_e   micro_op;
        logic        has_except;
        except_e     except_type;
    } rename_info_t;

    typedef struct packed {
        ftq_idx_t    ftq_idx;
        ftq_offset_t ftq_offset;
        logic        is_rvc;
        logic        is_mv;
        logic        has_rd;
        lreg_idx_t   lrd_idx;
        preg_idx_t   prd_idx;
        preg_idx_t   prev_prd_idx;
    } rob_entry_t;

    typedef struct packed {
        ftq_idx_t    ftq_idx;
        rob_idx_t    rob_idx;
        irb_idx_t    irb_idx;
        logic        rd_wen;
        preg_idx_t   prd_idx;
        preg_idx_t   prs1_idx;
        preg_idx_t   prs2_idx;
        logic        use_imm;
        micro_op_e   micro_op;
    } intdq_entry_t;

    typedef struct packed {
        rob_idx_t    rob_idx;
        except_e     except_type;
    } exceptwb_t;

endpackage

// ==== hdl/disp_queue.sv ====
`timescale 1ns/100ps

// in-order integer dispatch queue, RENAME_WIDTH in, INTDQ_DISP_WID out
module disp_queue
    import dispatch_cfg_pkg::*;
    import dispatch_types_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_flush,

    // enqueue side
    input  logic                      i_enq_vld,
    input  logic [RENAME_WIDTH-1:0]   i_enq_req,
    input  intdq_entry_t              i_enq_data [RENAME_WIDTH],
    output logic                      o_can_enq,

    // dequeue side
    output logic [INTDQ_DISP_WID-1:0] o_deq_vld,
    output intdq_entry_t              o_deq_data [INTDQ_DISP_WID],
    input  logic [INTDQ_DISP_WID-1:0] i_deq_req
);

    intdq_entry_t             mem [INTDQ_DEPTH];
    logic [INTDQ_PTR_W-1:0]   head;
    logic [INTDQ_PTR_W-1:0]   tail;
    logic [INTDQ_CNT_W-1:0]   count;

    logic [INTDQ_PTR_W-1:0]   enq_ofs [RENAME_WIDTH];
    logic [INTDQ_CNT_W-1:0]   enq_num;
    logic [INTDQ_CNT_W-1:0]   deq_num;
    logic                     do_enq;

    // room for a full rename group
    assign o_can_enq = (count <= INTDQ_CNT_W'(INTDQ_DEPTH - RENAME_WIDTH));
    assign do_enq    = i_enq_vld && o_can_enq && !i_flush;

    // compact requesting lanes, each gets its slot offset from tail
    always_comb begin
        enq_num = '0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            enq_ofs[i] = enq_num[INTDQ_PTR_W-1:0];
            if (i_enq_req[i]) begin
                enq_num = enq_num + 1'b1;
            end
        end
    end

    // port k shows the k-th oldest entry
    generate
        for (genvar k = 0; k < INTDQ_DISP_WID; k++) begin : g_deq
            assign o_deq_vld[k]  = (count > INTDQ_CNT_W'(k));
            assign o_deq_data[k] = mem[head + INTDQ_PTR_W'(k)];
        end
    endgenerate

    // issue takes a prefix of the valid ports
    always_comb begin
        deq_num = '0;
        for (int k = 0; k < INTDQ_DISP_WID; k++) begin
            if (i_deq_req[k] && o_deq_vld[k]) begin
                deq_num = deq_num + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head <= head + deq_num[INTDQ_PTR_W-1:0];
            if (do_enq) begin
                tail  <= tail + enq_num[INTDQ_PTR_W-1:0];
                count <= count + enq_num - deq_num;
            end else begin
                count <= count - deq_num;
            end
        end
    end

    // payload storage
    always_ff @(posedge clk) begin
        if (do_enq) begin
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                if (i_enq_req[i]) begin
                    mem[tail + enq_ofs[i]] <= i_enq_data[i];
                end
            end
        end
    end

endmodule

// ==== hdl/imm_buffer.sv ====
`timescale 1ns/100ps

// immediate store, allocated in order and freed out of order at writeback
module imm_buffer
    import dispatch_cfg_pkg::*;
    import dispatch_types_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        i_flush,

    // allocation from dispatch
    input  logic                        i_alloc_vld,
    input  logic [RENAME_WIDTH-1:0]     i_alloc_req,
    input  imm_t                        i_alloc_imm [RENAME_WIDTH],
    output irb_idx_t                    o_alloc_idx [RENAME_WIDTH],
    output logic                        o_can_alloc,

    // operand reads
    input  irb_idx_t                    i_read_idx [IMMBUF_READ_NUM],
    output imm_t                        o_read_imm [IMMBUF_READ_NUM],

    // frees at writeback
    input  logic [IMMBUF_CLEAR_NUM-1:0] i_clear_vld,
    input  irb_idx_t                    i_clear_idx [IMMBUF_CLEAR_NUM]
);

    imm_t                     store [IMMBUF_SIZE];
    logic [IMMBUF_SIZE-1:0]   valid;
    logic [IMMBUF_CNT_W-1:0]  free_cnt;
    logic                     alloc_fire;

    // lowest free entries, one lane after another
    always_comb begin
        logic [IMMBUF_SIZE-1:0] avail;
        logic                   found;
        avail = ~valid;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            o_alloc_idx[i] = '0;
            found          = 1'b0;
            if (i_alloc_req[i]) begin
                for (int e = 0; e < IMMBUF_SIZE; e++) begin
                    if (!found && avail[e]) begin
                        o_alloc_idx[i] = IRB_IDX_W'(e);
                        found          = 1'b1;
                    end
                end
                avail[o_alloc_idx[i]] = 1'b0;
            end
        end
    end

    always_comb begin
        free_cnt = '0;
        for (int e = 0; e < IMMBUF_SIZE; e++) begin
            free_cnt = free_cnt + IMMBUF_CNT_W'(!valid[e]);
        end
    end

    assign o_can_alloc = (free_cnt >= IMMBUF_CNT_W'(RENAME_WIDTH));
    assign alloc_fire  = i_alloc_vld && o_can_alloc && !i_flush;

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            valid <= '0;
        end else begin
            for (int c = 0; c < IMMBUF_CLEAR_NUM; c++) begin
                if (i_clear_vld[c]) begin
                    valid[i_clear_idx[c]] <= 1'b0;
                end
            end
            // alloc never hits an entry that is being cleared
            if (alloc_fire) begin
                for (int i = 0; i < RENAME_WIDTH; i++) begin
                    if (i_alloc_req[i]) begin
                        valid[o_alloc_idx[i]] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                if (i_alloc_req[i]) begin
                    store[o_alloc_idx[i]] <= i_alloc_imm[i];
                end
            end
        end
    end

    generate
        for (genvar r = 0; r < IMMBUF_READ_NUM; r++) begin : g_read
            assign o_read_imm[r] = store[i_read_idx[r]];
        end
    endgenerate

endmodule

// ==== hdl/dispatch.sv ====
`timescale 1ns/100ps

// dispatch stage, order-in lanes from rename
module dispatch
    import dispatch_cfg_pkg::*;
    import dispatch_types_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        i_squash,

    // rename side
    output logic                        o_stall,
    input  logic [RENAME_WIDTH-1:0]     i_enq_vld,
    input  rename_info_t                i_enq_inst [RENAME_WIDTH],

    // immediate reads and writeback frees
    input  irb_idx_t                    i_read_irb_idx [IMMBUF_READ_NUM],
    output imm_t                        o_read_irb_imm [IMMBUF_READ_NUM],
    input  logic [IMMBUF_CLEAR_NUM-1:0] i_clear_irb_vld,
    input  irb_idx_t                    i_clear_irb_idx [IMMBUF_CLEAR_NUM],

    // rob side
    input  logic                        i_can_insert_rob,
    output logic                        o_insert_rob_vld,
    output logic [RENAME_WIDTH-1:0]     o_insert_rob_req,
    output logic [RENAME_WIDTH-1:0]     o_insert_rob_ismv,
    output rob_entry_t                  o_rob_entry [RENAME_WIDTH],
    input  rob_idx_t                    i_alloc_rob_idx [RENAME_WIDTH],

    // front-end exception report
    output logic                        o_exceptwb_vld,
    output exceptwb_t                   o_exceptwb_info,

    // integer issue
    output logic [INTDQ_DISP_WID-1:0]   o_intdq_deq_vld,
    output intdq_entry_t                o_intdq_deq_entry [INTDQ_DISP_WID],
    input  logic [INTDQ_DISP_WID-1:0]   i_intdq_deq_req
);

    logic                    can_enq_intdq;
    logic                    can_alloc_imm;
    logic                    can_dispatch;
    logic                    disp_fire;

    logic [RENAME_WIDTH-1:0] intdq_req;
    logic [RENAME_WIDTH-1:0] imm_req;
    intdq_entry_t            intdq_entry [RENAME_WIDTH];
    imm_t                    imm_vec [RENAME_WIDTH];
    irb_idx_t                irb_idx [RENAME_WIDTH];

    logic                    exc_found;
    exceptwb_t               oldest_exc;
    logic                    exc_vld_q;
    exceptwb_t               exc_info_q;

    // whole group or nothing, mem side always has room
    assign can_dispatch = i_can_insert_rob && can_enq_intdq && can_alloc_imm;
    assign disp_fire    = can_dispatch && i_enq_vld[0];

    assign o_stall          = i_enq_vld[0] && !can_dispatch;
    assign o_insert_rob_vld = disp_fire;
    assign o_insert_rob_req = i_enq_vld;

    generate
        for (genvar i = 0; i < RENAME_WIDTH; i++) begin : g_lane
            // moves complete at the rob, never issued
            assign o_insert_rob_ismv[i] = i_enq_vld[i] && i_enq_inst[i].is_mv;
            assign intdq_req[i] = i_enq_vld[i] && (i_enq_inst[i].block_id == BLK_INT)
                                  && !i_enq_inst[i].is_mv;
            assign imm_req[i]   = i_enq_vld[i] && i_enq_inst[i].use_imm;
            assign imm_vec[i]   = i_enq_inst[i].imm20;

            assign o_rob_entry[i] = '{
                ftq_idx:      i_enq_inst[i].ftq_idx,
                ftq_offset:   i_enq_inst[i].ftq_offset,
                is_rvc:       i_enq_inst[i].is_rvc,
                is_mv:        i_enq_inst[i].is_mv,
                has_rd:       i_enq_inst[i].rd_wen,
                lrd_idx:      i_enq_inst[i].lrd_idx,
                prd_idx:      i_enq_inst[i].prd_idx,
                prev_prd_idx: i_enq_inst[i].prev_prd_idx
            };

            assign intdq_entry[i] = '{
                ftq_idx:  i_enq_inst[i].ftq_idx,
                rob_idx:  i_alloc_rob_idx[i],
                irb_idx:  irb_idx[i],
                rd_wen:   i_enq_inst[i].rd_wen,
                prd_idx:  i_enq_inst[i].prd_idx,
                prs1_idx: i_enq_inst[i].prs1_idx,
                prs2_idx: i_enq_inst[i].prs2_idx,
                use_imm:  i_enq_inst[i].use_imm,
                micro_op: i_enq_inst[i].micro_op
            };
        end
    endgenerate

    // oldest excepting lane is the lowest one
    always_comb begin
        exc_found  = 1'b0;
        oldest_exc = '0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            if (!exc_found && i_enq_vld[i] && i_enq_inst[i].has_except) begin
                exc_found              = 1'b1;
                oldest_exc.rob_idx     = i_alloc_rob_idx[i];
                oldest_exc.except_type = i_enq_inst[i].except_type;
            end
        end
    end

    // reported one cycle after dispatch, squash does not cancel it
    always_ff @(posedge clk) begin
        if (rst) begin
            exc_vld_q <= 1'b0;
        end else begin
            exc_vld_q <= disp_fire && exc_found;
        end
    end

    always_ff @(posedge clk) begin
        if (disp_fire && exc_found) begin
            exc_info_q <= oldest_exc;
        end
    end

    assign o_exceptwb_vld  = exc_vld_q;
    assign o_exceptwb_info = exc_info_q;

    disp_queue u_int_dispq (
        .clk        (clk),
        .rst        (rst),
        .i_flush    (i_squash),
        .i_enq_vld  (disp_fire),
        .i_enq_req  (intdq_req),
        .i_enq_data (intdq_entry),
        .o_can_enq  (can_enq_intdq),
        .o_deq_vld  (o_intdq_deq_vld),
        .o_deq_data (o_intdq_deq_entry),
        .i_deq_req  (i_intdq_deq_req)
    );

    imm_buffer u_imm_buf (
        .clk         (clk),
        .rst         (rst),
        .i_flush     (i_squash),
        .i_alloc_vld (disp_fire),
        .i_alloc_req (imm_req),
        .i_alloc_imm (imm_vec),
        .o_alloc_idx (irb_idx),
        .o_can_alloc (can_alloc_imm),
        .i_read_idx  (i_read_irb_idx),
        .o_read_imm  (o_read_irb_imm),
        .i_clear_vld (i_clear_irb_vld),
        .i_clear_idx (i_clear_irb_idx)
    );

endmodule

// ==== verif/dispatch_props.sv ====
`timescale 1ns/100ps

// handshake rules on the dispatch ports
module dispatch_props
    import dispatch_cfg_pkg::*;
(
    input logic                      clk,
    input logic                      rst,
    input logic [RENAME_WIDTH-1:0]   i_enq_vld,
    input logic                      o_stall,
    input logic                      o_insert_rob_vld,
    input logic                      o_exceptwb_vld,
    input logic [INTDQ_DISP_WID-1:0] o_intdq_deq_vld,
    input logic [INTDQ_DISP_WID-1:0] i_intdq_deq_req
);

    int prop_errs = 0;

    // rename fills lanes from lane 0 up
    enq_order_in: assert property (@(posedge clk) disable iff (rst)
        i_enq_vld[1] |-> i_enq_vld[0])
    else begin
        prop_errs++;
        $error("enq lane 1 valid without lane 0");
    end

    // issue takes the oldest entries only
    deq_prefix: assert property (@(posedge clk) disable iff (rst)
        (i_intdq_deq_req[1] |-> i_intdq_deq_req[0])
        && ((i_intdq_deq_req & ~o_intdq_deq_vld) == '0))
    else begin
        prop_errs++;
        $error("deq request is not a prefix of the valid ports");
    end

    no_insert_on_stall: assert property (@(posedge clk) disable iff (rst)
        o_stall |-> !o_insert_rob_vld)
    else begin
        prop_errs++;
        $error("rob insert while stalled");
    end

    // one report per dispatched group
    exc_single_pulse: assert property (@(posedge clk) disable iff (rst)
        (o_exceptwb_vld && !o_insert_rob_vld) |=> !o_exceptwb_vld)
    else begin
        prop_errs++;
        $error("exception writeback held without a new dispatch");
    end

endmodule

bind dispatch dispatch_props u_props (.*);

// ==== verif/tb_dispatch.sv ====
`timescale 1ns/100ps

module tb_dispatch
    import dispatch_cfg_pkg::*;
    import dispatch_types_pkg::*;
();

    // one line of the pattern file, numeric fields only
    typedef struct packed {
        logic [3:0] k0;
        logic [3:0] k1;
        logic       rob_ok;
        logic [1:0] mask;
        irb_idx_t   x;
        irb_idx_t   y;
        logic       st;
        logic [1:0] dv;
        logic       ex;
    } step_t;

    // what issue should see for one queued instruction
    typedef struct packed {
        ftq_idx_t  ftq_idx;
        rob_idx_t  rob_idx;
        irb_idx_t  irb_idx;
        logic      rd_wen;
        preg_idx_t prd_idx;
        preg_idx_t prs1_idx;
        preg_idx_t prs2_idx;
        logic      use_imm;
        imm_t      imm;
        micro_op_e micro_op;
    } exp_entry_t;

    logic                        clk;
    logic                        rst;
    logic                        squash;
    logic                        stall;
    logic [RENAME_WIDTH-1:0]     enq_vld;
    rename_info_t                enq_inst [RENAME_WIDTH];
    irb_idx_t                    read_idx [IMMBUF_READ_NUM];
    imm_t                        read_imm [IMMBUF_READ_NUM];
    logic [IMMBUF_CLEAR_NUM-1:0] clear_vld;
    irb_idx_t                    clear_idx [IMMBUF_CLEAR_NUM];
    logic                        can_insert_rob;
    logic                        insert_rob_vld;
    logic [RENAME_WIDTH-1:0]     insert_rob_req;
    logic [RENAME_WIDTH-1:0]     insert_rob_ismv;
    rob_entry_t                  rob_entry [RENAME_WIDTH];
    rob_idx_t                    alloc_rob_idx [RENAME_WIDTH];
    logic                        exceptwb_vld;
    exceptwb_t                   exceptwb_info;
    logic [INTDQ_DISP_WID-1:0]   deq_vld;
    intdq_entry_t                deq_entry [INTDQ_DISP_WID];
    logic [INTDQ_DISP_WID-1:0]   deq_req;

    string                  op_q [$];
    string                  name_q [$];
    step_t                  step_q [$];
    exp_entry_t             model_q [$];
    logic [IMMBUF_SIZE-1:0] imm_used;
    rob_idx_t               rob_cnt;
    exceptwb_t              exp_exc;
    logic                   held;
    integer                 seed = 72;
    int                     value_errs = 0;
    int                     other_errs = 0;
    int                     cycle_cnt;
    int                     cycle_limit = 0;

    dispatch dut (
        .clk               (clk),
        .rst               (rst),
        .i_squash          (squash),
        .o_stall           (stall),
        .i_enq_vld         (enq_vld),
        .i_enq_inst        (enq_inst),
        .i_read_irb_idx    (read_idx),
        .o_read_irb_imm    (read_imm),
        .i_clear_irb_vld   (clear_vld),
        .i_clear_irb_idx   (clear_idx),
        .i_can_insert_rob  (can_insert_rob),
        .o_insert_rob_vld  (insert_rob_vld),
        .o_insert_rob_req  (insert_rob_req),
        .o_insert_rob_ismv (insert_rob_ismv),
        .o_rob_entry       (rob_entry),
        .i_alloc_rob_idx   (alloc_rob_idx),
        .o_exceptwb_vld    (exceptwb_vld),
        .o_exceptwb_info   (exceptwb_info),
        .o_intdq_deq_vld   (deq_vld),
        .o_intdq_deq_entry (deq_entry),
        .i_intdq_deq_req   (deq_req)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_val(input string tname, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            value_errs++;
            $display("** Error %s: %s expected %0h, actual %0h", tname, what, exp, act);
        end
    endtask

    task automatic read_patterns();
        int    fd;
        int    cnt;
        int    k0, k1, rob, m, x, y, st, dv, ex;
        string line;
        string op;
        string name;
        step_t s;
        fd = $fopen("verif/dispatch_patterns.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("the pattern file could not be opened");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 4 || line.getc(0) == "#") begin
                continue;
            end
            cnt = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h",
                          op, name, k0, k1, rob, m, x, y, st, dv, ex);
            if (cnt != 11) begin
                other_errs++;
                $display("a pattern line holds %0d fields instead of 11", cnt);
                continue;
            end
            s = '{k0: 4'(k0), k1: 4'(k1), rob_ok: 1'(rob), mask: 2'(m), x: 3'(x),
                  y: 3'(y), st: 1'(st), dv: 2'(dv), ex: 1'(ex)};
            op_q.push_back(op);
            name_q.push_back(name);
            step_q.push_back(s);
        end
        $fclose(fd);
    endtask

    // random operands, kind picks block, micro-op, immediate and exception
    task automatic build_inst(input logic [3:0] kind, output rename_info_t inst);
        inst              = '0;
        inst.ftq_idx      = ftq_idx_t'($random(seed));
        inst.ftq_offset   = ftq_offset_t'($random(seed));
        inst.is_rvc       = 1'($random(seed));
        inst.rd_wen       = 1'($random(seed));
        inst.lrd_idx      = lreg_idx_t'($random(seed));
        inst.prd_idx      = preg_idx_t'($random(seed));
        inst.prev_prd_idx = preg_idx_t'($random(seed));
        inst.prs1_idx     = preg_idx_t'($random(seed));
        inst.prs2_idx     = preg_idx_t'($random(seed));
        inst.block_id     = BLK_INT;
        inst.micro_op     = UOP_ALU;
        inst.except_type  = EXC_NONE;
        case (kind)
            4'h2: begin
                inst.is_mv    = 1'b1;
                inst.micro_op = UOP_MV;
            end
            4'h3: begin
                inst.block_id = BLK_MEM;
                inst.micro_op = UOP_LOAD;
            end
            4'h4: begin
                inst.use_imm = 1'b1;
                inst.imm20   = imm_t'($random(seed));
            end
            4'h5: begin
                inst.has_except  = 1'b1;
                inst.except_type = EXC_ILLEGAL_INST;
            end
            4'h6: begin
                inst.micro_op    = UOP_BRANCH;
                inst.has_except  = 1'b1;
                inst.except_type = EXC_MISALIGNED_PC;
            end
            default: ;
        endcase
    endtask

    // rob record of one lane carries its rename fields
    task automatic check_rob_entry(input string tname, input int lane);
        check_val(tname, "rob ftq_idx", enq_inst[lane].ftq_idx, rob_entry[lane].ftq_idx);
        check_val(tname, "rob ftq_offset", enq_inst[lane].ftq_offset,
                  rob_entry[lane].ftq_offset);
        check_val(tname, "rob is_rvc", enq_inst[lane].is_rvc, rob_entry[lane].is_rvc);
        check_val(tname, "rob is_mv", enq_inst[lane].is_mv, rob_entry[lane].is_mv);
        check_val(tname, "rob has_rd", enq_inst[lane].rd_wen, rob_entry[lane].has_rd);
        check_val(tname, "rob lrd_idx", enq_inst[lane].lrd_idx, rob_entry[lane].lrd_idx);
        check_val(tname, "rob prd_idx", enq_inst[lane].prd_idx, rob_entry[lane].prd_idx);
        check_val(tname, "rob prev_prd_idx", enq_inst[lane].prev_prd_idx,
                  rob_entry[lane].prev_prd_idx);
    endtask

    // rob, queue and immediate buffer state after one clock edge
    task automatic update_model(input string op, input step_t s);
        int         npop;
        logic       exc_seen;
        exp_entry_t e;
        if (op == "deq") begin
            npop = s.mask[0] + s.mask[1];
            while (npop > 0 && model_q.size() > 0) begin
                void'(model_q.pop_front());
                npop--;
            end
        end
        if (s.k0 != 4'h0 && !s.st) begin
            exc_seen = 1'b0;
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                if (enq_vld[i]) begin
                    e          = '0;
                    e.ftq_idx  = enq_inst[i].ftq_idx;
                    e.rob_idx  = rob_cnt + rob_idx_t'(i);
                    e.rd_wen   = enq_inst[i].rd_wen;
                    e.prd_idx  = enq_inst[i].prd_idx;
                    e.prs1_idx = enq_inst[i].prs1_idx;
                    e.prs2_idx = enq_inst[i].prs2_idx;
                    e.use_imm  = enq_inst[i].use_imm;
                    e.imm      = enq_inst[i].imm20;
                    e.micro_op = enq_inst[i].micro_op;
                    if (e.use_imm) begin
                        // lowest free entry
                        for (int j = IMMBUF_SIZE - 1; j >= 0; j--) begin
                            if (!imm_used[j]) begin
                                e.irb_idx = irb_idx_t'(j);
                            end
                        end
                        imm_used[e.irb_idx] = 1'b1;
                    end
                    if (enq_inst[i].block_id == BLK_INT && !enq_inst[i].is_mv) begin
                        model_q.push_back(e);
                    end
                    if (enq_inst[i].has_except && !exc_seen) begin
                        exc_seen            = 1'b1;
                        exp_exc.rob_idx     = e.rob_idx;
                        exp_exc.except_type = enq_inst[i].except_type;
                    end
                end
            end
            rob_cnt = rob_cnt + enq_vld[0] + enq_vld[1];
        end
        if (op == "clr") begin
            if (s.mask[0]) begin
                imm_used[s.x] = 1'b0;
            end
            if (s.mask[1]) begin
                imm_used[s.y] = 1'b0;
            end
        end
        if (op == "squash") begin
            model_q.delete();
            imm_used = '0;
        end
    endtask

    task automatic check_registered(input string tname, input step_t s);
        exp_entry_t e;
        check_val(tname, "o_intdq_deq_vld", s.dv, deq_vld);
        check_val(tname, "o_exceptwb_vld", s.ex, exceptwb_vld);
        if (s.ex) begin
            check_val(tname, "o_exceptwb_info", exp_exc, exceptwb_info);
        end
        for (int k = 0; k < INTDQ_DISP_WID; k++) begin
            read_idx[k] = '0;
            if (s.dv[k]) begin
                assert (k < model_q.size()) else begin
                    other_errs++;
                    $display("test %s expects port %0d valid but the model queue is shorter",
                             tname, k);
                end
            end
            if (s.dv[k] && k < model_q.size()) begin
                e = model_q[k];
                check_val(tname, "deq ftq_idx", e.ftq_idx, deq_entry[k].ftq_idx);
                check_val(tname, "deq rob_idx", e.rob_idx, deq_entry[k].rob_idx);
                check_val(tname, "deq rd_wen", e.rd_wen, deq_entry[k].rd_wen);
                check_val(tname, "deq prd_idx", e.prd_idx, deq_entry[k].prd_idx);
                check_val(tname, "deq prs1_idx", e.prs1_idx, deq_entry[k].prs1_idx);
                check_val(tname, "deq prs2_idx", e.prs2_idx, deq_entry[k].prs2_idx);
                check_val(tname, "deq micro_op", e.micro_op, deq_entry[k].micro_op);
                check_val(tname, "deq use_imm", e.use_imm, deq_entry[k].use_imm);
                if (e.use_imm) begin
                    check_val(tname, "deq irb_idx", e.irb_idx, deq_entry[k].irb_idx);
                end
                read_idx[k] = e.irb_idx;
            end
        end
        #1;
        for (int k = 0; k < INTDQ_DISP_WID; k++) begin
            if (s.dv[k] && k < model_q.size() && model_q[k].use_imm) begin
                check_val(tname, "read imm", model_q[k].imm, read_imm[k]);
            end
        end
    endtask

    // entered 10 ns after a rising edge, left at the same point one cycle on
    task automatic run_step(input int idx);
        string      op;
        string      tname;
        step_t      s;
        logic [1:0] mv_mask;
        op    = op_q[idx];
        tname = name_q[idx];
        s     = step_q[idx];
        // rename holds a stalled group
        if (!held) begin
            build_inst(s.k0, enq_inst[0]);
            build_inst(s.k1, enq_inst[1]);
        end
        enq_vld          = {s.k1 != 4'h0, s.k0 != 4'h0};
        can_insert_rob   = s.rob_ok;
        alloc_rob_idx[0] = rob_cnt;
        alloc_rob_idx[1] = rob_cnt + 1'b1;
        deq_req          = (op == "deq") ? s.mask : 2'b00;
        clear_vld        = (op == "clr") ? s.mask : 2'b00;
        clear_idx[0]     = s.x;
        clear_idx[1]     = s.y;
        squash           = (op == "squash");
        // kind 2 is a register move
        mv_mask          = {s.k1 == 4'h2, s.k0 == 4'h2};
        #50;
        check_val(tname, "o_stall", s.st, stall);
        check_val(tname, "o_insert_rob_vld", enq_vld[0] && !s.st, insert_rob_vld);
        check_val(tname, "o_insert_rob_req", enq_vld, insert_rob_req);
        check_val(tname, "o_insert_rob_ismv", mv_mask, insert_rob_ismv);
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            if (enq_vld[i]) begin
                check_rob_entry(tname, i);
            end
        end
        @(posedge clk);
        update_model(op, s);
        held = s.st;
        #5;
        check_registered(tname, s);
        #4;
    endtask

    initial begin
        rst            = 1'b1;
        squash         = 1'b0;
        enq_vld        = '0;
        enq_inst       = '{default: '0};
        read_idx       = '{default: '0};
        clear_vld      = '0;
        clear_idx      = '{default: '0};
        can_insert_rob = 1'b0;
        alloc_rob_idx  = '{default: '0};
        deq_req        = '0;
        imm_used       = '0;
        rob_cnt        = '0;
        exp_exc        = '0;
        held           = 1'b0;
        read_patterns();
        cycle_limit = 16 + 6 * step_q.size() + 20;
        repeat (16) @(posedge clk);
        #10;
        rst = 1'b0;
        for (int st_i = 0; st_i < step_q.size(); st_i++) begin
            run_step(st_i);
        end
        $display("errors: %0d value, %0d other, %0d assertion",
                 value_errs, other_errs, dut.u_props.prop_errs);
        if (value_errs == 0 && other_errs == 0 && dut.u_props.prop_errs == 0
                && step_q.size() > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        @(posedge clk);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        other_errs++;
        $display("the run was stopped by the timeout after %0d cycles", cycle_cnt);
        $display("errors: %0d value, %0d other, %0d assertion",
                 value_errs, other_errs, dut.u_props.prop_errs);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== dispatch_sub.f ====
hdl/dispatch_cfg_pkg.sv
hdl/dispatch_types_pkg.sv
hdl/disp_queue.sv
hdl/imm_buffer.sv
hdl/dispatch.sv
verif/dispatch_props.sv
verif/tb_dispatch.sv

// ==== verif/dispatch_patterns.txt ====
# op name k0 k1 rob_ok mask x y then expected stall deq_vld exceptwb_vld
# kinds 0 none 1 alu 2 mv 3 load 4 alu+imm 5 alu+illegal 6 branch+misaligned
enq    alu_pair     1 1 1 0 0 0 0 3 0
deq    alu_deq      0 0 1 3 0 0 0 0 0
enq    mv_mem       2 3 1 0 0 0 0 0 0
enq    imm_pair_a   4 4 1 0 0 0 0 3 0
enq    imm_pair_b   4 4 1 0 0 0 0 3 0
deq    imm_deq_a    0 0 1 3 0 0 0 3 0
deq    imm_deq_b    0 0 1 3 0 0 0 0 0
enq    imm_fill_a   4 4 1 0 0 0 0 3 0
enq    imm_fill_b   4 4 1 0 0 0 0 3 0
enq    imm_full     1 0 1 0 0 0 1 3 0
clr    imm_clear    1 0 1 3 0 5 1 3 0
enq    imm_resume   1 0 1 0 0 0 0 3 0
enq    q_fill       1 1 1 0 0 0 0 3 0
enq    q_full       1 1 1 0 0 0 1 3 0
deq    q_drain      1 1 1 3 0 0 1 3 0
enq    q_resume     1 1 1 0 0 0 0 3 0
deq    drain_a      0 0 1 3 0 0 0 3 0
deq    drain_b      0 0 1 3 0 0 0 3 0
enq    rob_stall    5 6 0 0 0 0 1 3 0
enq    exc_pair     5 6 1 0 0 0 0 3 1
squash squash_all   0 0 1 0 0 0 0 0 0
enq    post_sq_a    4 4 1 0 0 0 0 3 0
enq    post_sq_b    4 4 1 0 0 0 0 3 0
enq    post_sq_c    4 4 1 0 0 0 0 3 0
enq    post_sq_d    4 4 1 0 0 0 0 3 0
deq    final_deq    0 0 1 3 0 0 0 3 0
